// File: hdl/fetch_pkg.sv
package fetch_pkg;

  // Address and instruction width.
  localparam int xlen = 32;

  // Every fetch returns an aligned pair of instructions.
  localparam int fetch_width = 64;

  // The first pair is fetched from here once reset is released.
  localparam logic [xlen-1:0] reset_pc = 32'h0000_0000;

  // Program counter FSM of the fetch stage.
  typedef enum logic [1:0] {
    idle = 2'd0, // No request outstanding, waiting for room in the buffer.
    busy = 2'd1, // One request outstanding whose response is wanted.
    ctrl = 2'd2, // The outstanding response belongs to the old path.
    inv  = 2'd3  // The memory is dropping its pending response after a fence.
  } fetch_state_t;

endpackage

// File: hdl/fetch_stage.sv
`timescale 1ns/1ns

module fetch_stage (
  input  logic                               clock,
  input  logic                               reset,
  input  logic                               redirect,
  input  logic [fetch_pkg::xlen-1:0]         redirect_pc,
  input  logic                               fence,
  input  logic [fetch_pkg::xlen-1:0]         fence_pc,
  input  logic                               mem_ready,
  input  logic [fetch_pkg::fetch_width-1:0]  mem_rdata,
  output logic                               mem_valid,
  output logic                               mem_fence,
  output logic                               mem_spec,
  output logic [fetch_pkg::xlen-1:0]         mem_addr,
  input  logic                               buf_stall,
  input  logic [fetch_pkg::xlen-1:0]         head_pc0,
  input  logic [fetch_pkg::xlen-1:0]         head_pc1,
  input  logic                               head_valid0,
  input  logic                               head_valid1,
  output logic [fetch_pkg::xlen-1:0]         buf_pc,
  output logic [fetch_pkg::fetch_width-1:0]  buf_rdata,
  output logic                               buf_ready,
  output logic                               buf_clear,
  output logic [fetch_pkg::xlen-1:0]         look_pc0,
  output logic [fetch_pkg::xlen-1:0]         look_pc1,
  input  logic                               hit0,
  input  logic                               hit1,
  input  logic [fetch_pkg::xlen-1:0]         target0,
  input  logic [fetch_pkg::xlen-1:0]         target1
);

  fetch_pkg::fetch_state_t state, state_nxt;

  logic [fetch_pkg::xlen-1:0] pc, pc_nxt, pc_seq;
  logic run;         // Low only in the first cycle after reset.
  logic outstanding;
  logic pred0, pred1, flush;

  // The predictor looks at the two instructions leaving the buffer.
  assign look_pc0 = head_pc0;
  assign look_pc1 = head_pc1;

  // A response always belongs to the pc of the request that is outstanding.
  assign buf_pc = pc;
  assign buf_rdata = mem_rdata;

  always_comb begin
    pred0 = head_valid0 && hit0;
    pred1 = head_valid1 && hit1 && !hit0;
    flush = redirect || fence || pred0 || pred1;
    pc_seq = {pc[fetch_pkg::xlen-1:3], 3'b000} + 8;

    pc_nxt = pc;
    if (redirect) begin
      pc_nxt = redirect_pc;
    end else if (fence) begin
      pc_nxt = fence_pc;
    end else if (pred0) begin
      pc_nxt = target0;
    end else if (pred1) begin
      pc_nxt = target1;
    end else if (state == fetch_pkg::busy && mem_ready) begin
      pc_nxt = pc_seq;
    end

    state_nxt = state;
    mem_valid = 1'b0;
    case (state)
      fetch_pkg::idle, fetch_pkg::inv: begin
        if (fence) begin
          state_nxt = fetch_pkg::inv;
        end else if (run && !buf_stall) begin
          state_nxt = fetch_pkg::busy;
          mem_valid = 1'b1;
        end else begin
          state_nxt = fetch_pkg::idle;
        end
      end
      fetch_pkg::busy: begin
        if (fence) begin
          state_nxt = fetch_pkg::inv;
        end else if (mem_ready) begin
          if (buf_stall) begin
            state_nxt = fetch_pkg::idle; // The pc already points past this pair.
          end else begin
            mem_valid = 1'b1;
          end
        end else if (flush) begin
          state_nxt = fetch_pkg::ctrl;
        end
      end
      fetch_pkg::ctrl: begin
        if (fence) begin
          state_nxt = fetch_pkg::inv;
        end else if (mem_ready) begin
          // The stale pair is dropped here and the new path starts.
          if (buf_stall) begin
            state_nxt = fetch_pkg::idle;
          end else begin
            state_nxt = fetch_pkg::busy;
            mem_valid = 1'b1;
          end
        end
      end
      default: begin
        state_nxt = fetch_pkg::idle;
      end
    endcase

    mem_fence = fence;
    mem_spec = flush;
    mem_addr = {pc_nxt[fetch_pkg::xlen-1:3], 3'b000};
    buf_ready = mem_ready && state == fetch_pkg::busy;
    buf_clear = flush;
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      state <= fetch_pkg::idle;
      pc <= fetch_pkg::reset_pc;
      run <= 1'b0;
      outstanding <= 1'b0;
    end else begin
      state <= state_nxt;
      pc <= pc_nxt;
      run <= 1'b1;
      if (mem_valid) begin
        outstanding <= 1'b1;
      end else if (mem_ready || mem_fence) begin
        outstanding <= 1'b0;
      end
    end
  end

  // Only one request may be in the memory at a time.
  assert property (@(posedge clock) disable iff (!reset)
    mem_valid |-> !outstanding || mem_ready);

endmodule

// File: hdl/fetch_buffer.sv
`timescale 1ns/1ns

module fetch_buffer #(
  parameter int queue_depth = 4
) (
  input  logic                              clock,
  input  logic                              reset,
  input  logic [fetch_pkg::xlen-1:0]        buf_pc,
  input  logic [fetch_pkg::fetch_width-1:0] buf_rdata,
  input  logic                              buf_ready,
  input  logic                              buf_clear,
  output logic                              buf_stall,
  output logic [fetch_pkg::xlen-1:0]        head_pc0,
  output logic [fetch_pkg::xlen-1:0]        head_pc1,
  output logic                              head_valid0,
  output logic                              head_valid1,
  input  logic                              hit0,
  input  logic                              decode_stall,
  output logic                              out_valid0,
  output logic [fetch_pkg::xlen-1:0]        out_pc0,
  output logic [fetch_pkg::xlen-1:0]        out_instr0,
  output logic                              out_valid1,
  output logic [fetch_pkg::xlen-1:0]        out_pc1,
  output logic [fetch_pkg::xlen-1:0]        out_instr1
);

  localparam int ptr_w = $clog2(queue_depth);
  localparam int cnt_w = $clog2(queue_depth + 1);
  localparam logic [cnt_w:0] stall_level = (cnt_w + 1)'(queue_depth - 2);
  localparam logic [cnt_w:0] full_level = (cnt_w + 1)'(queue_depth);

  logic [fetch_pkg::xlen-1:0] pc_q [queue_depth];
  logic [fetch_pkg::xlen-1:0] instr_q [queue_depth];
  logic [ptr_w-1:0] head, head1, tail, tail1;
  logic [cnt_w-1:0] count;
  logic [cnt_w:0] fill;
  logic [1:0] n_push, n_pop;
  logic aligned, write;

  function automatic logic [ptr_w-1:0] advance(input logic [ptr_w-1:0] ptr,
                                               input logic [1:0] step);
    int unsigned sum;
    sum = ptr + step;
    if (sum >= queue_depth) begin
      sum = sum - queue_depth;
    end
    return ptr_w'(sum);
  endfunction

  always_comb begin
    aligned = buf_pc[2] == 1'b0; // Otherwise only the upper instruction is wanted.
    write = buf_ready && !buf_clear;
    n_push = !write ? 2'd0 : (aligned ? 2'd2 : 2'd1);
    head1 = advance(head, 2'd1);
    tail1 = advance(tail, 2'd1);

    out_valid0 = count != '0;
    out_valid1 = count > cnt_w'(1) && !hit0;
    out_pc0 = pc_q[head];
    out_instr0 = instr_q[head];
    out_pc1 = pc_q[head1];
    out_instr1 = instr_q[head1];

    // The predictor sees the head entries, and they count only when they leave.
    head_pc0 = out_pc0;
    head_pc1 = out_pc1;
    head_valid0 = out_valid0 && !decode_stall;
    head_valid1 = out_valid1 && !decode_stall;
    n_pop = {1'b0, head_valid0} + {1'b0, head_valid1};

    // Two slots stay free for the response that may already be on its way.
    fill = (cnt_w + 1)'(count) + (cnt_w + 1)'(n_push);
    buf_stall = !buf_clear && fill > stall_level;
  end

  always_ff @(posedge clock) begin
    if (!reset || buf_clear) begin
      head <= '0;
      tail <= '0;
      count <= '0;
    end else begin
      head <= advance(head, n_pop);
      tail <= advance(tail, n_push);
      count <= count + cnt_w'(n_push) - cnt_w'(n_pop);
    end
  end

  always_ff @(posedge clock) begin
    if (write) begin
      if (aligned) begin
        pc_q[tail] <= buf_pc;
        instr_q[tail] <= buf_rdata[fetch_pkg::xlen-1:0];
        pc_q[tail1] <= {buf_pc[fetch_pkg::xlen-1:3], 3'b100};
        instr_q[tail1] <= buf_rdata[fetch_pkg::fetch_width-1:fetch_pkg::xlen];
      end else begin
        pc_q[tail] <= buf_pc;
        instr_q[tail] <= buf_rdata[fetch_pkg::fetch_width-1:fetch_pkg::xlen];
      end
    end
  end

  // The fetch stage must hold requests back before the queue can overflow.
  assert property (@(posedge clock) disable iff (!reset)
    write |-> fill <= full_level);

endmodule

// File: hdl/branch_target_cache.sv
`timescale 1ns/1ns

module branch_target_cache #(
  parameter int btc_entries = 8
) (
  input  logic                       clock,
  input  logic                       reset,
  input  logic [fetch_pkg::xlen-1:0] look_pc0,
  input  logic [fetch_pkg::xlen-1:0] look_pc1,
  output logic                       hit0,
  output logic [fetch_pkg::xlen-1:0] target0,
  output logic                       hit1,
  output logic [fetch_pkg::xlen-1:0] target1,
  input  logic                       upd_valid,
  input  logic [fetch_pkg::xlen-1:0] upd_pc,
  input  logic [fetch_pkg::xlen-1:0] upd_target,
  input  logic                       upd_taken
);

  localparam int idx_w = $clog2(btc_entries);
  localparam int tag_w = fetch_pkg::xlen - idx_w - 2;

  logic [btc_entries-1:0] valid_q;
  logic [tag_w-1:0] tag_q [btc_entries];
  logic [fetch_pkg::xlen-1:0] target_q [btc_entries];

  logic [idx_w-1:0] idx0, idx1, upd_idx;
  logic [tag_w-1:0] upd_tag;
  logic upd_match;

  // Instructions are word aligned, so the index starts at bit 2.
  function automatic logic [idx_w-1:0] index_of(input logic [fetch_pkg::xlen-1:0] pc);
    return pc[idx_w+1:2];
  endfunction

  function automatic logic [tag_w-1:0] tag_of(input logic [fetch_pkg::xlen-1:0] pc);
    return pc[fetch_pkg::xlen-1:idx_w+2];
  endfunction

  always_comb begin
    idx0 = index_of(look_pc0);
    idx1 = index_of(look_pc1);
    hit0 = valid_q[idx0] && tag_q[idx0] == tag_of(look_pc0);
    hit1 = valid_q[idx1] && tag_q[idx1] == tag_of(look_pc1);
    target0 = target_q[idx0];
    target1 = target_q[idx1];

    upd_idx = index_of(upd_pc);
    upd_tag = tag_of(upd_pc);
    upd_match = valid_q[upd_idx] && tag_q[upd_idx] == upd_tag;
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      valid_q <= '0;
    end else if (upd_valid) begin
      if (upd_taken) begin
        valid_q[upd_idx] <= 1'b1;
      end else if (upd_match) begin
        valid_q[upd_idx] <= 1'b0; // A branch that aliases here keeps its entry.
      end
    end
  end

  always_ff @(posedge clock) begin
    if (upd_valid && upd_taken) begin
      tag_q[upd_idx] <= upd_tag;
      target_q[upd_idx] <= upd_target;
    end
  end

endmodule

// File: hdl/instr_mem.sv
`timescale 1ns/1ns

module instr_mem #(
  parameter int mem_latency = 2,
  parameter int mem_words = 32
) (
  input  logic                              clock,
  input  logic                              reset,
  input  logic                              mem_valid,
  input  logic [fetch_pkg::xlen-1:0]        mem_addr,
  input  logic                              mem_fence,
  input  logic                              mem_spec,
  output logic                              mem_ready,
  output logic [fetch_pkg::fetch_width-1:0] mem_rdata
);

  localparam int idx_w = $clog2(mem_words);
  localparam int cnt_w = $clog2(mem_latency + 1);

  logic [fetch_pkg::fetch_width-1:0] words [mem_words];
  logic [fetch_pkg::fetch_width-1:0] data_q;
  logic [cnt_w-1:0] count;
  logic pending;

  initial begin
    $readmemh("dv/program.hex", words);
  end

  // The pair is read on acceptance and held until the next request.
  assign mem_ready = pending && count == cnt_w'(1);
  assign mem_rdata = data_q;

  always_ff @(posedge clock) begin
    if (!reset) begin
      pending <= 1'b0;
      count <= '0;
    end else if (mem_valid) begin
      pending <= 1'b1;
      count <= cnt_w'(mem_latency);
    end else if (mem_fence || mem_ready) begin
      pending <= 1'b0;
    end else if (pending) begin
      count <= count - cnt_w'(1);
    end
  end

  always_ff @(posedge clock) begin
    if (mem_valid) begin
      data_q <= words[mem_addr[idx_w+2:3]];
    end
  end

  // The fetch stage only ever asks for whole pairs.
  assert property (@(posedge clock) disable iff (!reset)
    mem_valid |-> mem_addr[2:0] == 3'b000);

  // A speculative request only follows the response of the earlier one.
  assert property (@(posedge clock) disable iff (!reset)
    mem_valid && mem_spec |-> !pending || mem_ready);

endmodule

// File: hdl/fetch_top.sv
`timescale 1ns/1ns

module fetch_top #(
  parameter int mem_latency = 2,
  parameter int mem_words = 32,
  parameter int btc_entries = 8,
  parameter int queue_depth = 4
) (
  input  logic                       clock,
  input  logic                       reset,
  input  logic                       redirect,
  input  logic [fetch_pkg::xlen-1:0] redirect_pc,
  input  logic                       fence,
  input  logic [fetch_pkg::xlen-1:0] fence_pc,
  input  logic                       upd_valid,
  input  logic [fetch_pkg::xlen-1:0] upd_pc,
  input  logic [fetch_pkg::xlen-1:0] upd_target,
  input  logic                       upd_taken,
  input  logic                       decode_stall,
  output logic                       out_valid0,
  output logic                       out_valid1,
  output logic [fetch_pkg::xlen-1:0] out_pc0,
  output logic [fetch_pkg::xlen-1:0] out_pc1,
  output logic [fetch_pkg::xlen-1:0] out_instr0,
  output logic [fetch_pkg::xlen-1:0] out_instr1
);

  logic mem_valid, mem_fence, mem_spec, mem_ready;
  logic [fetch_pkg::xlen-1:0] mem_addr, buf_pc, head_pc0, head_pc1;
  logic [fetch_pkg::xlen-1:0] look_pc0, look_pc1, target0, target1;
  logic [fetch_pkg::fetch_width-1:0] mem_rdata, buf_rdata;
  logic buf_ready, buf_clear, buf_stall, head_valid0, head_valid1, hit0, hit1;

  fetch_stage u_stage (
    .clock, .reset, .redirect, .redirect_pc, .fence, .fence_pc,
    .mem_ready, .mem_rdata, .mem_valid, .mem_fence, .mem_spec, .mem_addr,
    .buf_stall, .head_pc0, .head_pc1, .head_valid0, .head_valid1,
    .buf_pc, .buf_rdata, .buf_ready, .buf_clear,
    .look_pc0, .look_pc1, .hit0, .hit1, .target0, .target1
  );

  fetch_buffer #(.queue_depth(queue_depth)) u_buffer (
    .clock, .reset, .buf_pc, .buf_rdata, .buf_ready, .buf_clear, .buf_stall,
    .head_pc0, .head_pc1, .head_valid0, .head_valid1, .hit0, .decode_stall,
    .out_valid0, .out_pc0, .out_instr0, .out_valid1, .out_pc1, .out_instr1
  );

  branch_target_cache #(.btc_entries(btc_entries)) u_btc (
    .clock, .reset, .look_pc0, .look_pc1, .hit0, .target0, .hit1, .target1,
    .upd_valid, .upd_pc, .upd_target, .upd_taken
  );

  instr_mem #(.mem_latency(mem_latency), .mem_words(mem_words)) u_mem (
    .clock, .reset, .mem_valid, .mem_addr, .mem_fence, .mem_spec,
    .mem_ready, .mem_rdata
  );

endmodule

// File: dv/fetch_tb.sv
`timescale 1ns/1ns

module fetch_tb;

  localparam int total_instrs = 16 + 24 + 8 + 8 + 8 + 12 + 12;
  localparam int cycle_limit = 40 * total_instrs;

  logic clock;
  logic reset;
  logic redirect, fence, upd_valid, upd_taken, decode_stall;
  logic [31:0] redirect_pc, fence_pc, upd_pc, upd_target;
  logic out_valid0, out_valid1;
  logic [31:0] out_pc0, out_pc1, out_instr0, out_instr1;

  logic [63:0] program_words [32];
  logic [31:0] lfsr = 32'h0c6a0fd1;
  logic [31:0] exp_pc = fetch_pkg::reset_pc;
  logic model_valid [8];
  logic [31:0] model_pc [8];
  logic [31:0] model_target [8];
  int consumed = 0;
  int errors = 0;
  int cycles = 0;

  fetch_top #(.mem_latency(2), .mem_words(32), .btc_entries(8), .queue_depth(4)) DUT (
    .clock, .reset, .redirect, .redirect_pc, .fence, .fence_pc,
    .upd_valid, .upd_pc, .upd_target, .upd_taken, .decode_stall,
    .out_valid0, .out_valid1, .out_pc0, .out_pc1, .out_instr0, .out_instr1
  );

  initial begin
    clock = 1'b0;
    forever #5 clock = ~clock;
  end

  // Taps 32, 22, 2 and 1 give a maximal length sequence.
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic random_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      v = {v[30:0], lfsr[0]};
    end
  endtask

  // The lower half of a word holds the instruction at the 8-aligned pc.
  function automatic logic [31:0] ref_instr(input logic [31:0] pc);
    logic [63:0] word;
    word = program_words[pc[7:3]];
    return pc[2] ? word[63:32] : word[31:0];
  endfunction

  function automatic logic [31:0] ref_next_pc(input logic [31:0] pc);
    logic [2:0] idx;
    idx = pc[4:2];
    if (model_valid[idx] && model_pc[idx] == pc) begin
      return model_target[idx]; // Predicted taken.
    end
    return pc + 32'd4;
  endfunction

  task automatic check_slot(input logic [31:0] pc, input logic [31:0] instr);
    logic [31:0] want;
    want = ref_instr(exp_pc);
    assert (pc == exp_pc && instr == want) else begin
      errors++;
      $display("Error %0t: got pc %h instr %h, expected pc %h instr %h",
               $time, pc, instr, exp_pc, want);
    end
    exp_pc = ref_next_pc(exp_pc);
    consumed++;
  endtask

  // Lookups see the table from before the edge, so updates go in last.
  always @(posedge clock) begin
    if (reset) begin
      assert (!out_valid1 || out_valid0) else begin
        errors++;
        $display("Error %0t: out_valid1 is high while out_valid0 is low", $time);
      end
      if (out_valid0 && !decode_stall) begin
        check_slot(out_pc0, out_instr0);
        if (out_valid1) begin
          check_slot(out_pc1, out_instr1);
        end
      end
      if (redirect) begin
        exp_pc = redirect_pc;
      end else if (fence) begin
        exp_pc = fence_pc;
      end
      if (upd_valid) begin
        if (upd_taken) begin
          model_valid[upd_pc[4:2]] = 1'b1;
          model_pc[upd_pc[4:2]] = upd_pc;
          model_target[upd_pc[4:2]] = upd_target;
        end else if (model_pc[upd_pc[4:2]] == upd_pc) begin
          model_valid[upd_pc[4:2]] = 1'b0;
        end
      end
    end
  end

  always @(posedge clock) begin
    cycles++;
    if (cycles >= cycle_limit) begin
      $display("Timeout: the tests did not finish within %0d cycles", cycle_limit);
      $display("Summary: %0d instructions checked, %0d errors", consumed, errors);
      $display("Checks failed");
      $finish;
    end
  end

  task automatic consume(input int n, input bit random_stall);
    int target;
    logic [31:0] bits;
    target = consumed + n;
    while (consumed < target) begin
      @(negedge clock);
      if (random_stall) begin
        random_bits(1, bits);
        decode_stall = bits[0];
      end else begin
        decode_stall = 1'b0;
      end
    end
  endtask

  task automatic pulse_redirect(input logic [31:0] pc);
    @(negedge clock);
    redirect = 1'b1;
    redirect_pc = pc;
    @(negedge clock);
    redirect = 1'b0;
  endtask

  task automatic pulse_fence(input logic [31:0] pc);
    @(negedge clock);
    fence = 1'b1;
    fence_pc = pc;
    @(negedge clock);
    fence = 1'b0;
  endtask

  task automatic send_update(input logic [31:0] pc, input logic [31:0] target,
                             input logic taken);
    @(negedge clock);
    upd_valid = 1'b1;
    upd_pc = pc;
    upd_target = target;
    upd_taken = taken;
    @(negedge clock);
    upd_valid = 1'b0;
  endtask

  initial begin
    logic [31:0] bits;
    reset = 1'b0;
    redirect = 1'b0;
    redirect_pc = '0;
    fence = 1'b0;
    fence_pc = '0;
    upd_valid = 1'b0;
    upd_pc = '0;
    upd_target = '0;
    upd_taken = 1'b0;
    decode_stall = 1'b0;
    for (int i = 0; i < 8; i++) begin
      model_valid[i] = 1'b0;
      model_pc[i] = '0;
      model_target[i] = '0;
    end
    $readmemh("dv/program.hex", program_words);
    repeat (2) @(negedge clock);
    reset = 1'b1;
    assert (!out_valid0 && !out_valid1) else begin
      errors++;
      $display("Error %0t: decode outputs are valid straight after reset", $time);
    end

    consume(16, 1'b0);
    consume(24, 1'b1);
    pulse_redirect(32'h0000_0040);
    consume(8, 1'b1);
    pulse_redirect(32'h0000_0024); // Only the upper half of the pair is wanted.
    consume(8, 1'b1);
    pulse_fence(32'h0000_0010);
    consume(8, 1'b1);

    random_bits(5, bits);
    send_update(32'h0000_0058, {25'b0, bits[4:0], 2'b00}, 1'b1);
    pulse_redirect(32'h0000_0040);
    consume(12, 1'b1);
    send_update(32'h0000_0058, 32'h0, 1'b0);
    pulse_redirect(32'h0000_0040);
    consume(12, 1'b1);
    decode_stall = 1'b0;

    $display("Summary: %0d instructions checked, %0d errors", consumed, errors);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

// File: dv/program.hex
// One 64-bit word per line, upper instruction (pc+4) then lower instruction (pc).
// Each instruction is its pc in the upper 16 bits and the inverted pc in the lower 16.
0004fffb0000ffff
000cfff30008fff7
0014ffeb0010ffef
001cffe30018ffe7
0024ffdb0020ffdf
002cffd30028ffd7
0034ffcb0030ffcf
003cffc30038ffc7
0044ffbb0040ffbf
004cffb30048ffb7
0054ffab0050ffaf
005cffa30058ffa7
0064ff9b0060ff9f
006cff930068ff97
0074ff8b0070ff8f
007cff830078ff87
0084ff7b0080ff7f
008cff730088ff77
0094ff6b0090ff6f
009cff630098ff67
00a4ff5b00a0ff5f
00acff5300a8ff57
00b4ff4b00b0ff4f
00bcff4300b8ff47
00c4ff3b00c0ff3f
00ccff3300c8ff37
00d4ff2b00d0ff2f
00dcff2300d8ff27
00e4ff1b00e0ff1f
00ecff1300e8ff17
00f4ff0b00f0ff0f
00fcff0300f8ff07

// File: src.f
hdl/fetch_pkg.sv
hdl/fetch_stage.sv
hdl/fetch_buffer.sv
hdl/branch_target_cache.sv
hdl/instr_mem.sv
hdl/fetch_top.sv
dv/fetch_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the fetch testbench with Verilator from the project root.
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log
verilator --binary --timing --assert -Wno-fatal -f src.f --top-module fetch_tb \
  -o fetch_sim > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/fetch_sim > sim.log 2>&1
cat sim.log
grep -qx "All checks passed" sim.log && echo "PASS" && exit 0 || { echo "FAIL"; exit 1; }
